/* list.f */
source/acc_pkg.sv
source/axil_reg_file.sv
source/acc_engine.sv
source/read_source.sv
source/acc_periph_top.sv
tests/acc_periph_props.sv
tests/acc_periph_tb.sv

/* source/acc_engine.sv */
// accumulator engine summing accepted data words and counting them.
`timescale 1ns/10ps

module acc_engine #(
    parameter int DATA_W = 32
) (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic [DATA_W-1:0] ctrl_i,
    input  logic [DATA_W-1:0] data_i,
    input  logic              ctrl_wr_i,
    input  logic              data_wr_i,
    output logic [DATA_W-1:0] acc_o,
    output logic [DATA_W-1:0] count_o
);

    logic acc_en;
    logic acc_clr;

    // enable is a level, clear only counts when the control word is written.
    assign acc_en  = ctrl_i[acc_pkg::CTRL_EN_BIT];
    assign acc_clr = ctrl_wr_i & ctrl_i[acc_pkg::CTRL_CLR_BIT];

    // ******************************
    // sum and word count.
    // ******************************
    always_ff @(posedge clk_i) begin
        if (~rstn_i) begin
            acc_o   <= '0;
            count_o <= '0;
        end else if (acc_clr) begin
            acc_o   <= '0;
            count_o <= '0;
        end else if (data_wr_i && acc_en) begin
            acc_o   <= acc_o + data_i;    // wraps modulo 2**DATA_W.
            count_o <= count_o + 1'b1;
        end
    end

endmodule

/* source/acc_periph_top.sv */
// top level joining the axi4-lite register file, accumulator engine and read source.
`timescale 1ns/10ps

module acc_periph_top #(
    parameter int DATA_W  = acc_pkg::DATA_W,
    parameter int ADDR_W  = acc_pkg::ADDR_W,
    parameter int REG_NUM = acc_pkg::REG_NUM
) (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                awvalid_i,
    input  logic [ADDR_W-1:0]   awaddr_i,
    output logic                awready_o,
    input  logic                wvalid_i,
    input  logic [DATA_W-1:0]   wdata_i,
    input  logic [DATA_W/8-1:0] wstrb_i,
    output logic                wready_o,
    output logic                bvalid_o,
    output logic [1:0]          bresp_o,
    input  logic                bready_i,
    input  logic                arvalid_i,
    input  logic [ADDR_W-1:0]   araddr_i,
    output logic                arready_o,
    output logic                rvalid_o,
    output logic [DATA_W-1:0]   rdata_o,
    output logic [1:0]          rresp_o,
    input  logic                rready_i
);

    logic [REG_NUM-1:0][DATA_W-1:0] wr_regs;
    logic [REG_NUM-1:0]             wr_valid;
    logic [REG_NUM-1:0][DATA_W-1:0] rd_regs;
    logic [REG_NUM-1:0]             rd_valid;
    logic [REG_NUM-1:0]             rd_req;
    logic [DATA_W-1:0]              acc;
    logic [DATA_W-1:0]              count;

    axil_reg_file #(
        .DATA_W  (DATA_W),
        .ADDR_W  (ADDR_W),
        .REG_NUM (REG_NUM)
    ) u_axil_reg_file (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .awvalid_i  (awvalid_i),
        .awaddr_i   (awaddr_i),
        .awready_o  (awready_o),
        .wvalid_i   (wvalid_i),
        .wdata_i    (wdata_i),
        .wstrb_i    (wstrb_i),
        .wready_o   (wready_o),
        .bvalid_o   (bvalid_o),
        .bresp_o    (bresp_o),
        .bready_i   (bready_i),
        .arvalid_i  (arvalid_i),
        .araddr_i   (araddr_i),
        .arready_o  (arready_o),
        .rvalid_o   (rvalid_o),
        .rdata_o    (rdata_o),
        .rresp_o    (rresp_o),
        .rready_i   (rready_i),
        .rd_regs_i  (rd_regs),
        .rd_valid_i (rd_valid),
        .wr_regs_o  (wr_regs),
        .wr_valid_o (wr_valid),
        .rd_req_o   (rd_req)
    );

    // engine sees only the control and data registers.
    acc_engine #(
        .DATA_W (DATA_W)
    ) u_acc_engine (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .ctrl_i    (wr_regs[acc_pkg::REG_CTRL]),
        .data_i    (wr_regs[acc_pkg::REG_DATA]),
        .ctrl_wr_i (wr_valid[acc_pkg::REG_CTRL]),
        .data_wr_i (wr_valid[acc_pkg::REG_DATA]),
        .acc_o     (acc),
        .count_o   (count)
    );

    read_source #(
        .DATA_W  (DATA_W),
        .REG_NUM (REG_NUM)
    ) u_read_source (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .rd_req_i   (rd_req),
        .wr_regs_i  (wr_regs),
        .acc_i      (acc),
        .count_i    (count),
        .rd_regs_o  (rd_regs),
        .rd_valid_o (rd_valid)
    );

endmodule

/* source/acc_pkg.sv */
// shared bus widths, register map, control bit positions and response code.
package acc_pkg;

    // ******************************
    // bus widths and register count.
    // ******************************
    localparam int DATA_W  = 32;
    localparam int ADDR_W  = 8;
    localparam int REG_NUM = 5;

    // ******************************
    // register indices, word address bits 4:2.
    // ******************************
    localparam int REG_CTRL    = 0;
    localparam int REG_DATA    = 1;
    localparam int REG_ACC     = 2;  // read side returns the running sum.
    localparam int REG_COUNT   = 3;  // read side returns the word count.
    localparam int REG_SCRATCH = 4;

    // control register bits.
    localparam int CTRL_EN_BIT  = 0;
    localparam int CTRL_CLR_BIT = 1;  // acts only on the write strobe.

    // the only response this slave ever gives.
    localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

/* source/axil_reg_file.sv */
// axi4-lite slave with byte-strobed write registers, write strobes and read request capture.
`timescale 1ns/10ps

module axil_reg_file #(
    parameter int DATA_W  = 32,
    parameter int ADDR_W  = 8,
    parameter int REG_NUM = 5
) (
    input  logic                            clk_i,
    input  logic                            rstn_i,

    // write address channel.
    input  logic                            awvalid_i,
    input  logic [ADDR_W-1:0]               awaddr_i,
    output logic                            awready_o,

    // write data channel.
    input  logic                            wvalid_i,
    input  logic [DATA_W-1:0]               wdata_i,
    input  logic [DATA_W/8-1:0]             wstrb_i,
    output logic                            wready_o,

    // write response channel.
    output logic                            bvalid_o,
    output logic [1:0]                      bresp_o,
    input  logic                            bready_i,

    // read address channel.
    input  logic                            arvalid_i,
    input  logic [ADDR_W-1:0]               araddr_i,
    output logic                            arready_o,

    // read data channel.
    output logic                            rvalid_o,
    output logic [DATA_W-1:0]               rdata_o,
    output logic [1:0]                      rresp_o,
    input  logic                            rready_i,

    // register side.
    input  logic [REG_NUM-1:0][DATA_W-1:0]  rd_regs_i,
    input  logic [REG_NUM-1:0]              rd_valid_i,
    output logic [REG_NUM-1:0][DATA_W-1:0]  wr_regs_o,
    output logic [REG_NUM-1:0]              wr_valid_o,
    output logic [REG_NUM-1:0]              rd_req_o
);

    localparam int STRB_W   = DATA_W / 8;
    localparam int ADDR_LSB = 2;                 // word addressing.
    localparam int IDX_W    = $clog2(REG_NUM);

    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;
    logic             wr_go;
    logic             wr_hs;
    logic             ar_go;
    logic             ar_busy;   // a read is in flight until rdata is taken.
    logic             rd_pend;   // read source answers in this cycle.

    assign wr_idx = awaddr_i[ADDR_LSB +: IDX_W];
    assign rd_idx = araddr_i[ADDR_LSB +: IDX_W];

    assign bresp_o = acc_pkg::RESP_OKAY;
    assign rresp_o = acc_pkg::RESP_OKAY;

    // ******************************
    // write side.
    // ******************************

    // address and data are taken together, never while a response is pending.
    assign wr_go = awvalid_i & wvalid_i & ~awready_o & ~bvalid_o;
    assign wr_hs = awvalid_i & wvalid_i & awready_o & wready_o;

    always_ff @(posedge clk_i) begin
        if (~rstn_i) begin
            awready_o <= 1'b0;
            wready_o  <= 1'b0;
        end else begin
            awready_o <= wr_go;   // one-cycle pulse.
            wready_o  <= wr_go;
        end
    end

    always_ff @(posedge clk_i) begin
        if (~rstn_i) begin
            wr_regs_o  <= '0;
            wr_valid_o <= '0;
        end else begin
            wr_valid_o <= '0;
            for (int r = 0; r < REG_NUM; r++) begin
                if (wr_hs && wr_idx == r) begin
                    for (int b = 0; b < STRB_W; b++) begin
                        if (wstrb_i[b]) begin
                            wr_regs_o[r][b*8 +: 8] <= wdata_i[b*8 +: 8];
                        end
                    end
                    wr_valid_o[r] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (~rstn_i) begin
            bvalid_o <= 1'b0;
        end else if (wr_hs) begin
            bvalid_o <= 1'b1;
        end else if (bready_i) begin
            bvalid_o <= 1'b0;
        end
    end

    // ******************************
    // read side.
    // ******************************
    assign ar_go = arvalid_i & ~ar_busy;

    always_ff @(posedge clk_i) begin
        if (~rstn_i) begin
            arready_o <= 1'b0;
            ar_busy   <= 1'b0;
            rd_req_o  <= '0;
            rd_pend   <= 1'b0;
        end else begin
            arready_o <= ar_go;
            rd_req_o  <= '0;
            if (ar_go) begin
                ar_busy <= 1'b1;
                // unmapped index raises no request.
                for (int r = 0; r < REG_NUM; r++) begin
                    if (rd_idx == r) begin
                        rd_req_o[r] <= 1'b1;
                    end
                end
            end else if (rvalid_o && rready_i) begin
                ar_busy <= 1'b0;
            end
            rd_pend <= arready_o;
        end
    end

    // zero unless the read source answers.
    always_ff @(posedge clk_i) begin
        if (rd_pend) begin
            rdata_o <= '0;
            for (int r = 0; r < REG_NUM; r++) begin
                if (rd_valid_i[r]) begin
                    rdata_o <= rd_regs_i[r];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (~rstn_i) begin
            rvalid_o <= 1'b0;
        end else if (rd_pend) begin
            rvalid_o <= 1'b1;
        end else if (rvalid_o && rready_i) begin
            rvalid_o <= 1'b0;
        end
    end

endmodule

/* source/read_source.sv */
// read source returning the live register value for each read request.
`timescale 1ns/10ps

module read_source #(
    parameter int DATA_W  = 32,
    parameter int REG_NUM = 5
) (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    input  logic [REG_NUM-1:0]              rd_req_i,
    input  logic [REG_NUM-1:0][DATA_W-1:0]  wr_regs_i,
    input  logic [DATA_W-1:0]               acc_i,
    input  logic [DATA_W-1:0]               count_i,
    output logic [REG_NUM-1:0][DATA_W-1:0]  rd_regs_o,
    output logic [REG_NUM-1:0]              rd_valid_o
);

    // valid follows the request by one cycle.
    always_ff @(posedge clk_i) begin
        if (~rstn_i) begin
            rd_valid_o <= '0;
        end else begin
            rd_valid_o <= rd_req_i;
        end
    end

    // ******************************
    // value select per index.
    // ******************************
    always_ff @(posedge clk_i) begin
        for (int r = 0; r < REG_NUM; r++) begin
            if (rd_req_i[r]) begin
                if (r == acc_pkg::REG_ACC) begin
                    rd_regs_o[r] <= acc_i;
                end else if (r == acc_pkg::REG_COUNT) begin
                    rd_regs_o[r] <= count_i;
                end else begin
                    rd_regs_o[r] <= wr_regs_i[r];   // last written value.
                end
            end
        end
    end

endmodule

/* tests/acc_periph_props.sv */
// bound assertions for bus handshake and response codes of the accumulator peripheral.
`timescale 1ns/10ps

module acc_periph_props (
    input logic       clk_i,
    input logic       rstn_i,
    input logic       awvalid_i,
    input logic       awready_i,
    input logic       bvalid_i,
    input logic       bready_i,
    input logic [1:0] bresp_i,
    input logic       rvalid_i,
    input logic       rready_i,
    input logic [1:0] rresp_i
);

    int assert_fails = 0;

    // ******************************
    // valid holds until ready.
    // ******************************
    b_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        bvalid_i && !bready_i |=> bvalid_i)
        else begin
            $error("bvalid dropped before bready");
            assert_fails++;
        end

    r_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rvalid_i && !rready_i |=> rvalid_i)
        else begin
            $error("rvalid dropped before rready");
            assert_fails++;
        end

    aw_pulse: assert property (@(posedge clk_i) disable iff (!rstn_i)
        awready_i |-> awvalid_i)
        else begin
            $error("awready raised without awvalid");
            assert_fails++;
        end

    // slave never answers with anything but okay.
    b_okay: assert property (@(posedge clk_i) disable iff (!rstn_i)
        bvalid_i |-> bresp_i == acc_pkg::RESP_OKAY)
        else begin
            $error("bresp is not okay");
            assert_fails++;
        end

    r_okay: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rvalid_i |-> rresp_i == acc_pkg::RESP_OKAY)
        else begin
            $error("rresp is not okay");
            assert_fails++;
        end

endmodule

/* tests/acc_periph_tb.sv */
// testbench for the accumulator peripheral with lcg stimulus, reference model and watchdog.
`timescale 1ns/10ps

module acc_periph_tb;

    localparam int DW       = acc_pkg::DATA_W;
    localparam int AW       = acc_pkg::ADDR_W;
    localparam int NREG     = acc_pkg::REG_NUM;
    localparam int SCR_N    = 12;
    localparam int ACC_N    = 20;
    localparam int OFF_N    = 5;
    localparam int CLR_N    = 5;
    localparam int BP_N     = 16;
    localparam int UNMAPPED = 6;
    localparam int NUM_OPS  = 2*SCR_N + (ACC_N+3) + (OFF_N+3) + (CLR_N+5) + (BP_N+2) + 7;
    localparam int LIMIT    = NUM_OPS * 40 + 10;   // cycles, reset included.
    localparam int CTRL_EN  = 1 << acc_pkg::CTRL_EN_BIT;
    localparam int CTRL_CLR = 1 << acc_pkg::CTRL_CLR_BIT;

    logic            clk_i;
    logic            rstn_i;
    logic            awvalid_i;
    logic [AW-1:0]   awaddr_i;
    logic            awready_o;
    logic            wvalid_i;
    logic [DW-1:0]   wdata_i;
    logic [DW/8-1:0] wstrb_i;
    logic            wready_o;
    logic            bvalid_o;
    logic [1:0]      bresp_o;
    logic            bready_i;
    logic            arvalid_i;
    logic [AW-1:0]   araddr_i;
    logic            arready_o;
    logic            rvalid_o;
    logic [DW-1:0]   rdata_o;
    logic [1:0]      rresp_o;
    logic            rready_i;

    logic [31:0]   lcg_state;
    logic [2:0]    delay_mask;     // limits random bready/rready delays.
    logic [DW-1:0] model_regs [NREG];
    logic [DW-1:0] model_sum;
    logic [DW-1:0] model_count;
    int            err_count;
    int            tests_passed;
    int            tests_failed;

    acc_periph_top #(
        .DATA_W  (DW),
        .ADDR_W  (AW),
        .REG_NUM (NREG)
    ) u_acc_periph_top (.*);

    bind acc_periph_top acc_periph_props u_acc_periph_props (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .awvalid_i (awvalid_i),
        .awready_i (awready_o),
        .bvalid_i  (bvalid_o),
        .bready_i  (bready_i),
        .bresp_i   (bresp_o),
        .rvalid_i  (rvalid_o),
        .rready_i  (rready_i),
        .rresp_i   (rresp_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0] old_v,
                                                  input logic [DW-1:0] new_v,
                                                  input logic [DW/8-1:0] strb);
        logic [DW-1:0] res;
        res = old_v;
        for (int b = 0; b < DW/8; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = new_v[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // ******************************
    // reference model.
    // ******************************
    task automatic model_update(input int idx, input logic [DW-1:0] data,
                                input logic [DW/8-1:0] strb);
        if (idx < NREG) begin
            model_regs[idx] = merge_bytes(model_regs[idx], data, strb);
        end
        if (idx == acc_pkg::REG_CTRL && model_regs[idx][acc_pkg::CTRL_CLR_BIT]) begin
            model_sum   = '0;
            model_count = '0;
        end else if (idx == acc_pkg::REG_DATA &&
                     model_regs[acc_pkg::REG_CTRL][acc_pkg::CTRL_EN_BIT]) begin
            model_sum   = model_sum + model_regs[idx];   // wraps like the hardware.
            model_count = model_count + 1;
        end
    endtask

    function automatic logic [DW-1:0] expected_read(input int idx);
        if (idx == acc_pkg::REG_ACC) begin
            return model_sum;
        end else if (idx == acc_pkg::REG_COUNT) begin
            return model_count;
        end else if (idx < NREG) begin
            return model_regs[idx];
        end
        return '0;
    endfunction

    task automatic check_value(input logic [DW-1:0] got, input logic [DW-1:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s read %08h, expected %08h", $time, what, got, exp);
            err_count++;
        end
    endtask

    // ******************************
    // bus tasks.
    // ******************************
    task automatic axil_write(input int idx, input logic [DW-1:0] data,
                              input logic [DW/8-1:0] strb);
        logic [31:0] r;
        r = lcg_next();
        awvalid_i <= 1'b1;
        awaddr_i  <= {idx[AW-3:0], 2'b00};
        wvalid_i  <= 1'b1;
        wdata_i   <= data;
        wstrb_i   <= strb;
        do @(posedge clk_i); while (!(awready_o && wready_o));
        awvalid_i <= 1'b0;
        wvalid_i  <= 1'b0;
        do @(posedge clk_i); while (!bvalid_o);
        repeat (r[26:24] & delay_mask) @(posedge clk_i);
        bready_i <= 1'b1;
        do @(posedge clk_i); while (!(bvalid_o && bready_i));
        check_value(bresp_o, acc_pkg::RESP_OKAY, "bresp");
        bready_i <= 1'b0;
        model_update(idx, data, strb);
    endtask

    task automatic axil_read(input int idx, output logic [DW-1:0] data,
                             output logic [1:0] resp);
        logic [31:0] r;
        r = lcg_next();
        arvalid_i <= 1'b1;
        araddr_i  <= {idx[AW-3:0], 2'b00};
        do @(posedge clk_i); while (!arready_o);
        arvalid_i <= 1'b0;
        do @(posedge clk_i); while (!rvalid_o);
        repeat (r[26:24] & delay_mask) @(posedge clk_i);
        rready_i <= 1'b1;
        do @(posedge clk_i); while (!(rvalid_o && rready_i));
        data = rdata_o;
        resp = rresp_o;
        rready_i <= 1'b0;
    endtask

    task automatic read_check(input int idx, input string what);
        logic [DW-1:0] got;
        logic [1:0]    resp;
        axil_read(idx, got, resp);
        check_value(resp, acc_pkg::RESP_OKAY, "rresp");
        check_value(got, expected_read(idx), $sformatf("%s index %0d", what, idx));
    endtask

    task automatic read_expect(input int idx, input logic [DW-1:0] exp, input string what);
        logic [DW-1:0] got;
        logic [1:0]    resp;
        axil_read(idx, got, resp);
        check_value(resp, acc_pkg::RESP_OKAY, "rresp");
        check_value(got, exp, what);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail, %0d errors", name, err_count - errs_before);
        end
    endtask

    // ******************************
    // tests.
    // ******************************
    task automatic scratch_test();
        int          e0;
        logic [31:0] s;
        e0 = err_count;
        for (int i = 0; i < SCR_N; i++) begin
            s = lcg_next();
            axil_write(acc_pkg::REG_SCRATCH, lcg_next(), s[19:16]);
            read_check(acc_pkg::REG_SCRATCH, "scratch");
        end
        finish_test("scratch", e0);
    endtask

    task automatic accum_test();
        int e0;
        e0 = err_count;
        axil_write(acc_pkg::REG_CTRL, CTRL_CLR | CTRL_EN, '1);
        for (int i = 0; i < ACC_N; i++) begin
            axil_write(acc_pkg::REG_DATA, lcg_next(), '1);
        end
        read_check(acc_pkg::REG_ACC, "sum");
        read_expect(acc_pkg::REG_COUNT, ACC_N, "word count");
        finish_test("accumulate", e0);
    endtask

    task automatic enable_off_test();
        int            e0;
        logic [DW-1:0] sum0;
        logic [DW-1:0] cnt0;
        e0   = err_count;
        sum0 = model_sum;
        cnt0 = model_count;
        axil_write(acc_pkg::REG_CTRL, 0, '1);
        for (int i = 0; i < OFF_N; i++) begin
            axil_write(acc_pkg::REG_DATA, lcg_next(), '1);
        end
        read_expect(acc_pkg::REG_ACC, sum0, "sum with enable off");
        read_expect(acc_pkg::REG_COUNT, cnt0, "count with enable off");
        finish_test("enable off", e0);
    endtask

    task automatic clear_test();
        int e0;
        e0 = err_count;
        axil_write(acc_pkg::REG_CTRL, CTRL_CLR | CTRL_EN, '1);
        read_expect(acc_pkg::REG_ACC, 0, "sum after clear");
        read_expect(acc_pkg::REG_COUNT, 0, "count after clear");
        for (int i = 0; i < CLR_N; i++) begin
            axil_write(acc_pkg::REG_DATA, lcg_next(), '1);
        end
        read_check(acc_pkg::REG_ACC, "sum from zero");
        read_expect(acc_pkg::REG_COUNT, CLR_N, "count from zero");
        finish_test("clear", e0);
    endtask

    task automatic backpressure_test();
        int          e0;
        int          idx;
        logic [31:0] r;
        e0         = err_count;
        delay_mask = 3'd7;
        for (int i = 0; i < BP_N; i++) begin
            r   = lcg_next();
            idx = int'(r[30:28]) % NREG;
            if (r[31]) begin
                axil_write(idx, lcg_next(), r[19:16]);
            end else begin
                read_check(idx, "random read");
            end
        end
        read_check(acc_pkg::REG_CTRL, "last control");
        read_check(acc_pkg::REG_DATA, "last data");
        delay_mask = 3'd1;
        finish_test("back-pressure", e0);
    endtask

    task automatic unmapped_test();
        int e0;
        e0 = err_count;
        read_expect(UNMAPPED, 0, "unmapped read");
        axil_write(UNMAPPED, lcg_next(), '1);
        for (int k = 0; k < NREG; k++) begin
            read_check(k, "after unmapped write");
        end
        finish_test("unmapped", e0);
    endtask

    initial begin
        int fails;
        lcg_state    = 32'h0be7_1260;
        delay_mask   = 3'd1;
        err_count    = 0;
        tests_passed = 0;
        tests_failed = 0;
        model_sum    = '0;
        model_count  = '0;
        for (int k = 0; k < NREG; k++) begin
            model_regs[k] = '0;
        end
        rstn_i    <= 1'b0;
        awvalid_i <= 1'b0;
        awaddr_i  <= '0;
        wvalid_i  <= 1'b0;
        wdata_i   <= '0;
        wstrb_i   <= '0;
        bready_i  <= 1'b0;
        arvalid_i <= 1'b0;
        araddr_i  <= '0;
        rready_i  <= 1'b0;
        repeat (3) @(posedge clk_i);
        rstn_i <= 1'b1;
        @(posedge clk_i);
        scratch_test();
        accum_test();
        enable_off_test();
        clear_test();
        backpressure_test();
        unmapped_test();
        fails = u_acc_periph_top.u_acc_periph_props.assert_fails;
        $display("tests passed %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests_passed, tests_failed, err_count, fails);
        if (tests_failed == 0 && err_count == 0 && fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog.
    initial begin
        repeat (LIMIT) @(posedge clk_i);
        $display("timeout: the tests did not finish within %0d clock cycles", LIMIT);
        $display("*** FAILED ***");
        $finish;
    end

endmodule
